/* filelist.f */
+incdir+.
cpu_pkg.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
execute_unit.sv
writeback_unit.sv
pipelined_cpu.sv
tb_pipelined_cpu.sv

/* Makefile */
TOP = tb_pipelined_cpu
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb_pipelined_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_pipelined_cpu;

	localparam int MEM_DEPTH = 64;
	localparam int RAND_LEN  = 16;

	logic           clk;
	logic           reset_n;
	logic           read_m1;
	cpu_pkg::word_t address1;
	cpu_pkg::word_t data1;
	cpu_pkg::word_t output_port;
	cpu_pkg::word_t num_inst;
	logic           is_halted;

	cpu_pkg::word_t imem [MEM_DEPTH];
	// expected output port value after n instructions have retired
	cpu_pkg::word_t port_after [MEM_DEPTH+1];
	int             exp_count;
	int             prog_len;
	int             cycles;
	int             timeout_limit;
	int             mismatches;
	int             other_errors;
	integer         seed;
	logic           reset_prev = 1'b1;

	pipelined_cpu u_dut (
		.clk           (clk),
		.reset_n       (reset_n),
		.read_m1_o     (read_m1),
		.address1_o    (address1),
		.data1_i       (data1),
		.output_port_o (output_port),
		.num_inst_o    (num_inst),
		.is_halted_o   (is_halted)
	);

	// instruction memory answers in the same cycle
	assign data1 = (address1 < MEM_DEPTH) ? imem[address1[$clog2(MEM_DEPTH)-1:0]] : '0;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		reset_prev <= reset_n;
	end

	function automatic cpu_pkg::word_t encode_rtype(input cpu_pkg::func_t fn,
			input cpu_pkg::reg_idx_t rs, input cpu_pkg::reg_idx_t rt,
			input cpu_pkg::reg_idx_t rd);
		return {`CPU_OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic cpu_pkg::word_t encode_itype(input cpu_pkg::opcode_t op,
			input cpu_pkg::reg_idx_t rs, input cpu_pkg::reg_idx_t rt, input cpu_pkg::imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input cpu_pkg::word_t instr);
		imem[prog_len] = instr;
		prog_len++;
	endtask

	task automatic load_program();
		int                kind;
		cpu_pkg::imm_t     imm;
		cpu_pkg::reg_idx_t rs;
		cpu_pkg::reg_idx_t rt;
		cpu_pkg::reg_idx_t rd;
		// unused words are ADI r0 with their own address as immediate
		for (int i = 0; i < MEM_DEPTH; i++) begin
			imem[i] = encode_itype(`CPU_OP_ADI, 2'd0, 2'd0, cpu_pkg::imm_t'(i));
		end
		seed = 32060;
		for (int i = 0; i < RAND_LEN; i++) begin
			kind = $unsigned($random(seed)) % 11;
			imm  = cpu_pkg::imm_t'($random(seed));
			rs   = cpu_pkg::reg_idx_t'($random(seed));
			rt   = cpu_pkg::reg_idx_t'($random(seed));
			rd   = cpu_pkg::reg_idx_t'($random(seed));
			if (i % 4 == 3) begin
				emit(encode_rtype(`CPU_FN_WWD, rs, 2'd0, 2'd0));
			end else if (kind < 8) begin
				// function codes 0 to 7 are the ALU operations
				emit(encode_rtype(cpu_pkg::func_t'(kind), rs, rt, rd));
			end else if (kind == 8) begin
				emit(encode_itype(`CPU_OP_ADI, rs, rt, imm));
			end else if (kind == 9) begin
				emit(encode_itype(`CPU_OP_ORI, rs, rt, imm));
			end else begin
				emit(encode_itype(`CPU_OP_LHI, rs, rt, imm));
			end
		end
		// immediate extension rules
		emit(encode_rtype(`CPU_FN_SUB, 2'd0, 2'd0, 2'd0));
		emit(encode_itype(`CPU_OP_ADI, 2'd0, 2'd1, 8'h80));
		emit(encode_rtype(`CPU_FN_WWD, 2'd1, 2'd0, 2'd0));
		emit(encode_itype(`CPU_OP_ADI, 2'd1, 2'd1, 8'hf3));
		emit(encode_itype(`CPU_OP_ORI, 2'd0, 2'd2, 8'hf0));
		emit(encode_rtype(`CPU_FN_WWD, 2'd2, 2'd0, 2'd0));
		emit(encode_itype(`CPU_OP_LHI, 2'd0, 2'd3, 8'ha5));
		emit(encode_rtype(`CPU_FN_WWD, 2'd3, 2'd0, 2'd0));
		// dependent chains at distance one and two
		emit(encode_rtype(`CPU_FN_ADD, 2'd1, 2'd3, 2'd1));
		emit(encode_rtype(`CPU_FN_SUB, 2'd1, 2'd2, 2'd2));
		emit(encode_rtype(`CPU_FN_ORR, 2'd1, 2'd2, 2'd0));
		emit(encode_rtype(`CPU_FN_WWD, 2'd0, 2'd0, 2'd0));
		emit(encode_rtype(`CPU_FN_NOT, 2'd0, 2'd0, 2'd3));
		emit(encode_rtype(`CPU_FN_TCP, 2'd3, 2'd0, 2'd3));
		emit(encode_rtype(`CPU_FN_SHL, 2'd3, 2'd0, 2'd1));
		emit(encode_rtype(`CPU_FN_SHR, 2'd1, 2'd0, 2'd1));
		emit(encode_rtype(`CPU_FN_AND, 2'd1, 2'd3, 2'd2));
		emit(encode_rtype(`CPU_FN_WWD, 2'd2, 2'd0, 2'd0));
		emit(encode_rtype(`CPU_FN_WWD, 2'd1, 2'd0, 2'd0));
		emit(encode_rtype(`CPU_FN_HLT, 2'd0, 2'd0, 2'd0));
		// never retires
		emit(encode_itype(`CPU_OP_ADI, 2'd0, 2'd0, 8'h55));
		emit(encode_rtype(`CPU_FN_WWD, 2'd0, 2'd0, 2'd0));
	endtask

	// in-order ISA model of the program
	task automatic run_model();
		cpu_pkg::word_t regs [4];
		cpu_pkg::word_t instr;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t port;
		cpu_pkg::imm_t  imm;
		int             pc;
		logic           halted;
		for (int i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		port          = '0;
		port_after[0] = '0;
		exp_count     = 0;
		halted        = 1'b0;
		pc            = 0;
		while (!halted && pc < MEM_DEPTH) begin
			instr = imem[pc];
			pc++;
			a   = regs[instr[11:10]];
			b   = regs[instr[9:8]];
			imm = instr[7:0];
			exp_count++;
			case (instr[15:12])
				`CPU_OP_RTYPE: begin
					case (instr[5:0])
						`CPU_FN_ADD: regs[instr[7:6]] = a + b;
						`CPU_FN_SUB: regs[instr[7:6]] = a - b;
						`CPU_FN_AND: regs[instr[7:6]] = a & b;
						`CPU_FN_ORR: regs[instr[7:6]] = a | b;
						`CPU_FN_NOT: regs[instr[7:6]] = ~a;
						`CPU_FN_TCP: regs[instr[7:6]] = ~a + 16'd1;
						`CPU_FN_SHL: regs[instr[7:6]] = {a[14:0], 1'b0};
						`CPU_FN_SHR: regs[instr[7:6]] = {a[15], a[15:1]};
						`CPU_FN_WWD: port = a;
						`CPU_FN_HLT: halted = 1'b1;
						default: ;
					endcase
				end
				`CPU_OP_ADI: regs[instr[9:8]] = a + {{8{imm[7]}}, imm};
				`CPU_OP_ORI: regs[instr[9:8]] = a | {8'h00, imm};
				`CPU_OP_LHI: regs[instr[9:8]] = {imm, 8'h00};
				default: ;
			endcase
			port_after[exp_count] = port;
		end
	endtask

	a_reset_state : assert property (@(posedge clk)
		!reset_prev |-> (!read_m1 && !is_halted && num_inst == '0 && output_port == '0)
	) else begin
		mismatches++;
		$display("MISMATCH reset_state: expected %h actual %h", 34'h0,
			$sampled({read_m1, is_halted, num_inst, output_port}));
	end

	a_count_bound : assert property (@(posedge clk) disable iff (!reset_n)
		num_inst <= exp_count
	) else begin
		other_errors++;
		$display("more instructions retired than the program holds up to HLT");
	end

	a_wwd_output : assert property (@(posedge clk) disable iff (!reset_n)
		(num_inst <= exp_count) |-> output_port == port_after[num_inst]
	) else begin
		mismatches++;
		$display("MISMATCH wwd_output: expected %h actual %h",
			port_after[$sampled(num_inst)], $sampled(output_port));
	end

	a_halt_count : assert property (@(posedge clk) disable iff (!reset_n)
		$rose(is_halted) |-> num_inst == exp_count
	) else begin
		mismatches++;
		$display("MISMATCH halt_count: expected %0d actual %0d", exp_count, $sampled(num_inst));
	end

	// PC must hold as well once the CPU has halted
	a_halt_frozen : assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> ($stable(num_inst) && $stable(output_port) && $stable(address1)
			&& !read_m1)
	) else begin
		other_errors++;
		$display("CPU state changed or fetch resumed after halt");
	end

	initial begin
		reset_n      = 1'b0;
		mismatches   = 0;
		other_errors = 0;
		cycles       = 0;
		prog_len     = 0;
		load_program();
		run_model();
		timeout_limit = prog_len + 40;
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;
		while (!is_halted && cycles < timeout_limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!is_halted) begin
			other_errors++;
			$display("timeout: CPU did not halt within %0d cycles", timeout_limit);
		end else begin
			// give the post-halt checks a few edges
			repeat (8) @(posedge clk);
			#1;
		end
		$display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* pipelined_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelined_cpu (
	input  wire                 clk,
	input  wire                 reset_n,
	output logic                read_m1_o,
	output cpu_pkg::word_t      address1_o,
	input  wire cpu_pkg::word_t data1_i,
	output cpu_pkg::word_t      output_port_o,
	output cpu_pkg::word_t      num_inst_o,
	output logic                is_halted_o
);

	// fetch to decode
	cpu_pkg::word_t    if_instr;
	logic              if_valid;
	logic              halt_seen;

	// decode to execute
	cpu_pkg::word_t    id_rs_val;
	cpu_pkg::word_t    id_rt_val;
	cpu_pkg::word_t    id_imm;
	cpu_pkg::alu_op_e  id_alu_op;
	logic              id_use_imm;
	cpu_pkg::reg_idx_t id_dest;
	logic              id_reg_write;
	logic              id_is_wwd;
	logic              id_is_hlt;
	cpu_pkg::reg_idx_t id_rs_idx;
	cpu_pkg::reg_idx_t id_rt_idx;
	logic              id_valid;

	// execute to writeback
	cpu_pkg::word_t    ex_result;
	cpu_pkg::word_t    ex_wwd_val;
	cpu_pkg::reg_idx_t ex_dest;
	logic              ex_reg_write;
	logic              ex_is_wwd;
	logic              ex_is_hlt;
	logic              ex_valid;

	// retire write, shared by register file and forwarding
	logic              wb_we;
	cpu_pkg::reg_idx_t wb_idx;
	cpu_pkg::word_t    wb_data;

	fetch_unit u_fetch (
		.clk        (clk),
		.reset_n    (reset_n),
		.halt_i     (halt_seen),
		.read_m1_o  (read_m1_o),
		.address1_o (address1_o),
		.data1_i    (data1_i),
		.if_instr_o (if_instr),
		.if_valid_o (if_valid)
	);

	decode_unit u_decode (
		.clk            (clk),
		.reset_n        (reset_n),
		.if_instr_i     (if_instr),
		.if_valid_i     (if_valid),
		.wb_we_i        (wb_we),
		.wb_idx_i       (wb_idx),
		.wb_data_i      (wb_data),
		.halt_seen_o    (halt_seen),
		.id_rs_val_o    (id_rs_val),
		.id_rt_val_o    (id_rt_val),
		.id_imm_o       (id_imm),
		.id_alu_op_o    (id_alu_op),
		.id_use_imm_o   (id_use_imm),
		.id_dest_o      (id_dest),
		.id_reg_write_o (id_reg_write),
		.id_is_wwd_o    (id_is_wwd),
		.id_is_hlt_o    (id_is_hlt),
		.id_rs_idx_o    (id_rs_idx),
		.id_rt_idx_o    (id_rt_idx),
		.id_valid_o     (id_valid)
	);

	execute_unit u_execute (
		.clk            (clk),
		.reset_n        (reset_n),
		.id_rs_val_i    (id_rs_val),
		.id_rt_val_i    (id_rt_val),
		.id_imm_i       (id_imm),
		.id_alu_op_i    (id_alu_op),
		.id_use_imm_i   (id_use_imm),
		.id_dest_i      (id_dest),
		.id_reg_write_i (id_reg_write),
		.id_is_wwd_i    (id_is_wwd),
		.id_is_hlt_i    (id_is_hlt),
		.id_rs_idx_i    (id_rs_idx),
		.id_rt_idx_i    (id_rt_idx),
		.id_valid_i     (id_valid),
		.wb_we_i        (wb_we),
		.wb_idx_i       (wb_idx),
		.wb_data_i      (wb_data),
		.ex_result_o    (ex_result),
		.ex_wwd_val_o   (ex_wwd_val),
		.ex_dest_o      (ex_dest),
		.ex_reg_write_o (ex_reg_write),
		.ex_is_wwd_o    (ex_is_wwd),
		.ex_is_hlt_o    (ex_is_hlt),
		.ex_valid_o     (ex_valid)
	);

	writeback_unit u_writeback (
		.clk            (clk),
		.reset_n        (reset_n),
		.ex_result_i    (ex_result),
		.ex_wwd_val_i   (ex_wwd_val),
		.ex_dest_i      (ex_dest),
		.ex_reg_write_i (ex_reg_write),
		.ex_is_wwd_i    (ex_is_wwd),
		.ex_is_hlt_i    (ex_is_hlt),
		.ex_valid_i     (ex_valid),
		.wb_we_o        (wb_we),
		.wb_idx_o       (wb_idx),
		.wb_data_o      (wb_data),
		.output_port_o  (output_port_o),
		.num_inst_o     (num_inst_o),
		.is_halted_o    (is_halted_o)
	);

endmodule

`default_nettype wire

/* writeback_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
	input  wire                    clk,
	input  wire                    reset_n,
	input  wire cpu_pkg::word_t    ex_result_i,
	input  wire cpu_pkg::word_t    ex_wwd_val_i,
	input  wire cpu_pkg::reg_idx_t ex_dest_i,
	input  wire                    ex_reg_write_i,
	input  wire                    ex_is_wwd_i,
	input  wire                    ex_is_hlt_i,
	input  wire                    ex_valid_i,
	output logic                   wb_we_o,
	output cpu_pkg::reg_idx_t      wb_idx_o,
	output cpu_pkg::word_t         wb_data_o,
	output cpu_pkg::word_t         output_port_o,
	output cpu_pkg::word_t         num_inst_o,
	output logic                   is_halted_o
);

	// register file write, also the forwarding source for execute
	assign wb_we_o   = ex_valid_i && ex_reg_write_i;
	assign wb_idx_o  = ex_dest_i;
	assign wb_data_o = ex_result_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_port_o <= '0;
			num_inst_o    <= '0;
			is_halted_o   <= 1'b0;
		end else if (ex_valid_i) begin
			// every retiring instruction counts, WWD and HLT included
			num_inst_o <= num_inst_o + 1'b1;
			if (ex_is_wwd_i) begin
				output_port_o <= ex_wwd_val_i;
			end
			if (ex_is_hlt_i) begin
				is_halted_o <= 1'b1;
			end
		end
	end

	// nothing may retire behind the HLT
	a_count_frozen : assert property (
		@(posedge clk) disable iff (!reset_n)
		is_halted_o |=> $stable(num_inst_o)
	) else $error("num_inst_o changed after halt");

endmodule

`default_nettype wire

/* execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire                    clk,
	input  wire                    reset_n,
	input  wire cpu_pkg::word_t    id_rs_val_i,
	input  wire cpu_pkg::word_t    id_rt_val_i,
	input  wire cpu_pkg::word_t    id_imm_i,
	input  wire cpu_pkg::alu_op_e  id_alu_op_i,
	input  wire                    id_use_imm_i,
	input  wire cpu_pkg::reg_idx_t id_dest_i,
	input  wire                    id_reg_write_i,
	input  wire                    id_is_wwd_i,
	input  wire                    id_is_hlt_i,
	input  wire cpu_pkg::reg_idx_t id_rs_idx_i,
	input  wire cpu_pkg::reg_idx_t id_rt_idx_i,
	input  wire                    id_valid_i,
	input  wire                    wb_we_i,
	input  wire cpu_pkg::reg_idx_t wb_idx_i,
	input  wire cpu_pkg::word_t    wb_data_i,
	output cpu_pkg::word_t         ex_result_o,
	output cpu_pkg::word_t         ex_wwd_val_o,
	output cpu_pkg::reg_idx_t      ex_dest_o,
	output logic                   ex_reg_write_o,
	output logic                   ex_is_wwd_o,
	output logic                   ex_is_hlt_o,
	output logic                   ex_valid_o
);

	cpu_pkg::word_t op_a;
	cpu_pkg::word_t fwd_b;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t alu_res;

	// instruction one ahead is retiring now, take its result directly
	assign op_a  = (wb_we_i && wb_idx_i == id_rs_idx_i) ? wb_data_i : id_rs_val_i;
	assign fwd_b = (wb_we_i && wb_idx_i == id_rt_idx_i) ? wb_data_i : id_rt_val_i;
	assign op_b  = id_use_imm_i ? id_imm_i : fwd_b;

	always_comb begin
		case (id_alu_op_i)
			cpu_pkg::ALU_ADD:    alu_res = op_a + op_b;
			cpu_pkg::ALU_SUB:    alu_res = op_a - op_b;
			cpu_pkg::ALU_AND:    alu_res = op_a & op_b;
			cpu_pkg::ALU_OR:     alu_res = op_a | op_b;
			cpu_pkg::ALU_NOT:    alu_res = ~op_a;
			cpu_pkg::ALU_TCP:    alu_res = -op_a;
			cpu_pkg::ALU_SHL:    alu_res = op_a << 1;
			// arithmetic shift, sign bit kept
			cpu_pkg::ALU_SHR:    alu_res = cpu_pkg::word_t'($signed(op_a) >>> 1);
			cpu_pkg::ALU_PASS_B: alu_res = op_b;
			default:             alu_res = op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_valid_o     <= 1'b0;
			ex_reg_write_o <= 1'b0;
			ex_is_wwd_o    <= 1'b0;
			ex_is_hlt_o    <= 1'b0;
		end else begin
			ex_valid_o     <= id_valid_i;
			ex_reg_write_o <= id_reg_write_i;
			ex_is_wwd_o    <= id_is_wwd_i;
			ex_is_hlt_o    <= id_is_hlt_i;
		end
	end

	// WWD outputs its rs operand
	always_ff @(posedge clk) begin
		ex_result_o  <= alu_res;
		ex_wwd_val_o <= op_a;
		ex_dest_o    <= id_dest_i;
	end

endmodule

`default_nettype wire

/* decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decode_unit (
	input  wire                    clk,
	input  wire                    reset_n,
	input  wire cpu_pkg::word_t    if_instr_i,
	input  wire                    if_valid_i,
	input  wire                    wb_we_i,
	input  wire cpu_pkg::reg_idx_t wb_idx_i,
	input  wire cpu_pkg::word_t    wb_data_i,
	output logic                   halt_seen_o,
	output cpu_pkg::word_t         id_rs_val_o,
	output cpu_pkg::word_t         id_rt_val_o,
	output cpu_pkg::word_t         id_imm_o,
	output cpu_pkg::alu_op_e       id_alu_op_o,
	output logic                   id_use_imm_o,
	output cpu_pkg::reg_idx_t      id_dest_o,
	output logic                   id_reg_write_o,
	output logic                   id_is_wwd_o,
	output logic                   id_is_hlt_o,
	output cpu_pkg::reg_idx_t      id_rs_idx_o,
	output cpu_pkg::reg_idx_t      id_rt_idx_o,
	output logic                   id_valid_o
);

	cpu_pkg::opcode_t  opcode;
	cpu_pkg::func_t    func;
	cpu_pkg::reg_idx_t rs;
	cpu_pkg::reg_idx_t rt;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::imm_t     imm;
	cpu_pkg::word_t    rs_val;
	cpu_pkg::word_t    rt_val;
	cpu_pkg::word_t    imm_ext;
	cpu_pkg::alu_op_e  alu_op;
	cpu_pkg::reg_idx_t dest;
	logic              use_imm;
	logic              reg_write;
	logic              is_wwd;
	logic              is_hlt;
	logic              halt_q;
	logic              load;

	assign opcode = if_instr_i[`CPU_OP_MSB:`CPU_OP_LSB];
	assign rs     = if_instr_i[`CPU_RS_MSB:`CPU_RS_LSB];
	assign rt     = if_instr_i[`CPU_RT_MSB:`CPU_RT_LSB];
	assign rd     = if_instr_i[`CPU_RD_MSB:`CPU_RD_LSB];
	assign func   = if_instr_i[`CPU_FN_MSB:`CPU_FN_LSB];
	assign imm    = if_instr_i[`CPU_IMM_MSB:`CPU_IMM_LSB];

	register_file u_regs (
		.clk         (clk),
		.reset_n     (reset_n),
		.rd_idx_a_i  (rs),
		.rd_idx_b_i  (rt),
		.rd_data_a_o (rs_val),
		.rd_data_b_o (rt_val),
		.we_i        (wb_we_i),
		.wr_idx_i    (wb_idx_i),
		.wr_data_i   (wb_data_i)
	);

	always_comb begin
		alu_op    = cpu_pkg::ALU_PASS_B;
		use_imm   = 1'b0;
		imm_ext   = '0;
		dest      = rd;
		reg_write = 1'b0;
		is_wwd    = 1'b0;
		is_hlt    = 1'b0;
		case (opcode)
			`CPU_OP_RTYPE: begin
				reg_write = 1'b1;
				case (func)
					`CPU_FN_ADD: alu_op = cpu_pkg::ALU_ADD;
					`CPU_FN_SUB: alu_op = cpu_pkg::ALU_SUB;
					`CPU_FN_AND: alu_op = cpu_pkg::ALU_AND;
					`CPU_FN_ORR: alu_op = cpu_pkg::ALU_OR;
					`CPU_FN_NOT: alu_op = cpu_pkg::ALU_NOT;
					`CPU_FN_TCP: alu_op = cpu_pkg::ALU_TCP;
					`CPU_FN_SHL: alu_op = cpu_pkg::ALU_SHL;
					`CPU_FN_SHR: alu_op = cpu_pkg::ALU_SHR;
					`CPU_FN_WWD: begin
						is_wwd    = 1'b1;
						reg_write = 1'b0;
					end
					`CPU_FN_HLT: begin
						is_hlt    = 1'b1;
						reg_write = 1'b0;
					end
					// unknown function retires as a no-op
					default: reg_write = 1'b0;
				endcase
			end
			`CPU_OP_ADI: begin
				alu_op    = cpu_pkg::ALU_ADD;
				use_imm   = 1'b1;
				imm_ext   = {{(`CPU_WORD_SIZE-`CPU_IMM_MSB-1){imm[`CPU_IMM_MSB]}}, imm};
				dest      = rt;
				reg_write = 1'b1;
			end
			`CPU_OP_ORI: begin
				alu_op    = cpu_pkg::ALU_OR;
				use_imm   = 1'b1;
				imm_ext   = cpu_pkg::word_t'(imm);
				dest      = rt;
				reg_write = 1'b1;
			end
			`CPU_OP_LHI: begin
				// immediate into the upper byte, lower byte cleared
				use_imm   = 1'b1;
				imm_ext   = {imm, {(`CPU_WORD_SIZE-`CPU_IMM_MSB-1){1'b0}}};
				dest      = rt;
				reg_write = 1'b1;
			end
			default: ;
		endcase
	end

	// the HLT itself goes through, everything behind it becomes a bubble
	assign load        = if_valid_i && !halt_q;
	assign halt_seen_o = halt_q || (load && is_hlt);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			halt_q         <= 1'b0;
			id_valid_o     <= 1'b0;
			id_reg_write_o <= 1'b0;
			id_is_wwd_o    <= 1'b0;
			id_is_hlt_o    <= 1'b0;
		end else begin
			halt_q         <= halt_seen_o;
			id_valid_o     <= load;
			id_reg_write_o <= load && reg_write;
			id_is_wwd_o    <= load && is_wwd;
			id_is_hlt_o    <= load && is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		id_rs_val_o  <= rs_val;
		id_rt_val_o  <= rt_val;
		id_imm_o     <= imm_ext;
		id_alu_op_o  <= alu_op;
		id_use_imm_o <= use_imm;
		id_dest_o    <= dest;
		id_rs_idx_o  <= rs;
		id_rt_idx_o  <= rt;
	end

	a_hlt_no_write : assert property (
		@(posedge clk) disable iff (!reset_n)
		!(id_is_hlt_o && id_reg_write_o)
	) else $error("HLT in execute with reg_write set");

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module register_file (
	input  wire                    clk,
	input  wire                    reset_n,
	input  wire cpu_pkg::reg_idx_t rd_idx_a_i,
	input  wire cpu_pkg::reg_idx_t rd_idx_b_i,
	output cpu_pkg::word_t         rd_data_a_o,
	output cpu_pkg::word_t         rd_data_b_o,
	input  wire                    we_i,
	input  wire cpu_pkg::reg_idx_t wr_idx_i,
	input  wire cpu_pkg::word_t    wr_data_i
);

	cpu_pkg::word_t regs [`CPU_NUM_REGS];
	logic           hit_a;
	logic           hit_b;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// write-through so a read in the writing cycle sees the new value
	assign hit_a = we_i && (wr_idx_i == rd_idx_a_i);
	assign hit_b = we_i && (wr_idx_i == rd_idx_b_i);

	assign rd_data_a_o = hit_a ? wr_data_i : regs[rd_idx_a_i];
	assign rd_data_b_o = hit_b ? wr_data_i : regs[rd_idx_b_i];

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                 clk,
	input  wire                 reset_n,
	input  wire                 halt_i,
	output logic                read_m1_o,
	output cpu_pkg::word_t      address1_o,
	input  wire cpu_pkg::word_t data1_i,
	output cpu_pkg::word_t      if_instr_o,
	output logic                if_valid_o
);

	cpu_pkg::word_t pc;
	logic           fetch_ok;

	// a fetch only counts while the strobe is up and no halt is pending
	assign fetch_ok   = read_m1_o && !halt_i;
	assign address1_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc         <= '0;
			read_m1_o  <= 1'b0;
			if_valid_o <= 1'b0;
		end else begin
			// strobe rises one cycle out of reset, drops for good once halted
			read_m1_o  <= !halt_i;
			// the word fetched alongside a decoded HLT is squashed here
			if_valid_o <= fetch_ok;
			if (fetch_ok) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// instruction word, qualified by if_valid_o
	always_ff @(posedge clk) begin
		if_instr_o <= data1_i;
	end

	// once decode has flagged a halt, no further fetches go out
	a_no_fetch_after_halt : assert property (
		@(posedge clk) disable iff (!reset_n)
		$past(halt_i) |-> !read_m1_o
	) else $error("read_m1_o high after halt");

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

	// instruction fields
	typedef logic [`CPU_OP_MSB-`CPU_OP_LSB:0] opcode_t;
	typedef logic [`CPU_FN_MSB-`CPU_FN_LSB:0] func_t;
	typedef logic [`CPU_IMM_MSB-`CPU_IMM_LSB:0] imm_t;

	// operations the execute stage can perform
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire

/* cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath sizes
`define CPU_WORD_SIZE 16
`define CPU_NUM_REGS  4

// instruction field positions
`define CPU_OP_MSB  15
`define CPU_OP_LSB  12
`define CPU_RS_MSB  11
`define CPU_RS_LSB  10
`define CPU_RT_MSB  9
`define CPU_RT_LSB  8
`define CPU_RD_MSB  7
`define CPU_RD_LSB  6
`define CPU_FN_MSB  5
`define CPU_FN_LSB  0
`define CPU_IMM_MSB 7
`define CPU_IMM_LSB 0

// opcodes
`define CPU_OP_RTYPE 4'd15
`define CPU_OP_ADI   4'd4
`define CPU_OP_ORI   4'd5
`define CPU_OP_LHI   4'd6

// function codes under the R-type opcode
`define CPU_FN_ADD 6'd0
`define CPU_FN_SUB 6'd1
`define CPU_FN_AND 6'd2
`define CPU_FN_ORR 6'd3
`define CPU_FN_NOT 6'd4
`define CPU_FN_TCP 6'd5
`define CPU_FN_SHL 6'd6
`define CPU_FN_SHR 6'd7
`define CPU_FN_WWD 6'd28
`define CPU_FN_HLT 6'd29

`endif
